//--- design/tube_pkg.sv
package tube_pkg;

    localparam int value_width = 32;
    localparam int digit_count = 8;
    localparam int bcd_width   = 32;                // four bits per position
    localparam int conv_cycles = 32;                // one shift per value bit

    localparam logic addr_value = 1'b0;
    localparam logic addr_ctrl  = 1'b1;             // bit 0 enable, bit 1 hex_mode

    // segment order is {g, f, e, d, c, b, a}, a zero bit lights the segment
    localparam logic [6:0] seg_blank = 7'b111_1111;

    localparam logic [6:0] glyph_0 = 7'b100_0000;
    localparam logic [6:0] glyph_1 = 7'b111_1001;
    localparam logic [6:0] glyph_2 = 7'b010_0100;
    localparam logic [6:0] glyph_3 = 7'b011_0000;
    localparam logic [6:0] glyph_4 = 7'b001_1001;
    localparam logic [6:0] glyph_5 = 7'b001_0010;
    localparam logic [6:0] glyph_6 = 7'b000_0010;
    localparam logic [6:0] glyph_7 = 7'b111_1000;
    localparam logic [6:0] glyph_8 = 7'b000_0000;
    localparam logic [6:0] glyph_9 = 7'b001_0000;
    localparam logic [6:0] glyph_a = 7'b000_1000;
    localparam logic [6:0] glyph_b = 7'b000_0011;   // lower case b
    localparam logic [6:0] glyph_c = 7'b100_0110;
    localparam logic [6:0] glyph_d = 7'b010_0001;   // lower case d
    localparam logic [6:0] glyph_e = 7'b000_0110;
    localparam logic [6:0] glyph_f = 7'b000_1110;

endpackage

//--- design/tube_cfg_if.sv
interface tube_cfg_if;

    import tube_pkg::*;

    logic [value_width-1:0] value;      // value register, also read as hex nibbles
    logic                   enable;     // display on
    logic                   hex_mode;   // 0 shows decimal, 1 shows hex
    logic                   value_wr;   // one cycle pulse on a value write

    modport regs (
        output value,
        output enable,
        output hex_mode,
        output value_wr
    );

    modport conv (
        input  value,
        input  value_wr
    );

    modport scan (
        input  enable,
        input  hex_mode
    );

endinterface

//--- design/tube_regs.sv
module tube_regs (
    input  logic                              clk_tube,
    input  logic                              rst_n,
    input  logic                              host_req,
    input  logic                              host_addr,
    input  logic [tube_pkg::value_width-1:0]  host_wdata,
    output logic                              host_ack,
    tube_cfg_if.regs                          cfg
);

    import tube_pkg::*;

    typedef enum logic {
        ack_idle,
        ack_hold
    } ack_state_t;

    ack_state_t state;

    // a write is taken once per req, ack then holds until req drops
    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ack_idle;
            cfg.value    <= '0;
            cfg.enable   <= 1'b0;
            cfg.hex_mode <= 1'b0;
            cfg.value_wr <= 1'b0;
        end else begin
            cfg.value_wr <= 1'b0;
            case (state)
                ack_idle: begin
                    if (host_req) begin
                        state <= ack_hold;
                        if (host_addr == addr_value) begin
                            cfg.value    <= host_wdata;
                            cfg.value_wr <= 1'b1;     // same edge as ack rising
                        end else if (host_addr == addr_ctrl) begin
                            cfg.enable   <= host_wdata[0];
                            cfg.hex_mode <= host_wdata[1];
                        end
                    end
                end
                ack_hold: begin
                    if (!host_req) begin
                        state <= ack_idle;
                    end
                end
                default: begin
                    state <= ack_idle;
                end
            endcase
        end
    end

    assign host_ack = (state == ack_hold);

endmodule

//--- design/bin_to_bcd.sv
module bin_to_bcd (
    input  logic                            clk_tube,
    input  logic                            rst_n,
    tube_cfg_if.conv                        cfg,
    output logic [tube_pkg::bcd_width-1:0]  bcd_digits
);

    import tube_pkg::*;

    localparam int work_width = bcd_width + value_width;

    logic [work_width-1:0] work;    // {bcd digits, remaining binary bits}
    logic [4:0]            step;    // shifts done so far
    logic                  busy;
    logic                  done;

    // one double dabble step: add 3 to every digit of 5 or more, then shift
    function automatic logic [work_width-1:0] dabble_step(input logic [work_width-1:0] w);
        logic [work_width-1:0] t;
        t = w;
        for (int i = 0; i < digit_count; i++) begin
            if (t[value_width + 4*i +: 4] >= 4'd5) begin
                t[value_width + 4*i +: 4] = t[value_width + 4*i +: 4] + 4'd3;
            end
        end
        // a carry out of the top digit is lost, which leaves the value mod 10^8
        return t << 1;
    endfunction

    always_ff @(posedge clk_tube) begin
        if (cfg.value_wr) begin
            work <= dabble_step({{bcd_width{1'b0}}, cfg.value}); // first shift on capture
        end else if (busy) begin
            work <= dabble_step(work);
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            step <= 5'd0;
            busy <= 1'b0;
            done <= 1'b0;
        end else if (cfg.value_wr) begin
            step <= 5'd1;                   // a new write restarts the conversion
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy) begin
            if (step == 5'(conv_cycles - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                step <= step + 5'd1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    // old digits stay on the tubes until a conversion completes
    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            bcd_digits <= '0;
        end else if (done) begin
            bcd_digits <= work[work_width-1 -: bcd_width];
        end
    end

endmodule

//--- design/digit_scanner.sv
module digit_scanner (
    input  logic                                clk_tube,
    input  logic                                rst_n,
    tube_cfg_if.scan                            cfg,
    input  logic [tube_pkg::bcd_width-1:0]      bcd_digits,
    input  logic [tube_pkg::value_width-1:0]    hex_value,
    output logic [3:0]                          digit,
    output logic                                blank,
    output logic [tube_pkg::digit_count-1:0]    pos_enable
);

    import tube_pkg::*;

    logic [2:0]             pos;            // 7 is the leftmost tube
    logic                   zero_run;       // only zeros so far in this sweep
    logic                   lead;
    logic [digit_count-1:0] pos_onehot;

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            pos      <= 3'(digit_count - 1);
            zero_run <= 1'b1;
        end else begin
            pos      <= pos - 3'd1;         // wraps from 0 back to 7
            zero_run <= lead && (digit == 4'd0);
        end
    end

    always_comb begin
        if (cfg.hex_mode) begin
            digit = hex_value[4*pos +: 4];
        end else begin
            digit = bcd_digits[4*pos +: 4];
        end

        lead = (pos == 3'(digit_count - 1)) || zero_run;

        pos_onehot      = '0;
        pos_onehot[pos] = 1'b1;

        if (!cfg.enable) begin
            blank      = 1'b1;
            pos_enable = '1;                // all tubes off
        end else begin
            // the rightmost tube stays lit so zero reads as 0
            blank      = !cfg.hex_mode && lead && (digit == 4'd0) && (pos != 3'd0);
            pos_enable = ~pos_onehot;
        end
    end

endmodule

//--- design/seg_decoder.sv
module seg_decoder (
    input  logic                                clk_tube,
    input  logic                                rst_n,
    input  logic [3:0]                          digit,
    input  logic                                blank,
    input  logic [tube_pkg::digit_count-1:0]    pos_enable,
    output logic [6:0]                          seg_tube,
    output logic [tube_pkg::digit_count-1:0]    seg_enable
);

    import tube_pkg::*;

    logic [6:0] glyph;

    always_comb begin
        case (digit)
            4'h0:    glyph = glyph_0;
            4'h1:    glyph = glyph_1;
            4'h2:    glyph = glyph_2;
            4'h3:    glyph = glyph_3;
            4'h4:    glyph = glyph_4;
            4'h5:    glyph = glyph_5;
            4'h6:    glyph = glyph_6;
            4'h7:    glyph = glyph_7;
            4'h8:    glyph = glyph_8;
            4'h9:    glyph = glyph_9;
            4'ha:    glyph = glyph_a;
            4'hb:    glyph = glyph_b;
            4'hc:    glyph = glyph_c;
            4'hd:    glyph = glyph_d;
            4'he:    glyph = glyph_e;
            default: glyph = glyph_f;
        endcase
    end

    // segments and position enable leave on the same edge
    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            seg_tube   <= seg_blank;
            seg_enable <= '1;
        end else begin
            seg_tube   <= blank ? seg_blank : glyph;
            seg_enable <= pos_enable;
        end
    end

endmodule

//--- design/tube_display_top.sv
module tube_display_top (
    input  logic                                clk_tube,
    input  logic                                rst_n,

    input  logic                                host_req,
    input  logic                                host_addr,
    input  logic [tube_pkg::value_width-1:0]    host_wdata,
    output logic                                host_ack,

    output logic [6:0]                          seg_tube,
    output logic [tube_pkg::digit_count-1:0]    seg_enable
);

    import tube_pkg::*;

    tube_cfg_if cfg ();

    logic [bcd_width-1:0]   bcd_digits;
    logic [3:0]             digit;
    logic                   blank;
    logic [digit_count-1:0] pos_enable;

    tube_regs u_regs (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .cfg        (cfg.regs)
    );

    bin_to_bcd u_bcd (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .cfg        (cfg.conv),
        .bcd_digits (bcd_digits)
    );

    digit_scanner u_scan (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .cfg        (cfg.scan),
        .bcd_digits (bcd_digits),
        .hex_value  (cfg.value),        // hex mode shows the raw register
        .digit      (digit),
        .blank      (blank),
        .pos_enable (pos_enable)
    );

    seg_decoder u_dec (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .digit      (digit),
        .blank      (blank),
        .pos_enable (pos_enable),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

endmodule

//--- testbench/display_ref.svh
`ifndef display_ref_svh
`define display_ref_svh

// active low segments in {g, f, e, d, c, b, a} order
function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
    logic [6:0] seg;
    case (nibble)
        4'h0:    seg = 7'h40;
        4'h1:    seg = 7'h79;
        4'h2:    seg = 7'h24;
        4'h3:    seg = 7'h30;
        4'h4:    seg = 7'h19;
        4'h5:    seg = 7'h12;
        4'h6:    seg = 7'h02;
        4'h7:    seg = 7'h78;
        4'h8:    seg = 7'h00;
        4'h9:    seg = 7'h10;
        4'ha:    seg = 7'h08;
        4'hb:    seg = 7'h03;   // lower case b
        4'hc:    seg = 7'h46;
        4'hd:    seg = 7'h21;   // lower case d
        4'he:    seg = 7'h06;
        default: seg = 7'h0e;
    endcase
    return seg;
endfunction

// glyph expected at one tube position, position 0 is the rightmost
function automatic logic [6:0] expected_glyph(input logic [31:0] value, input logic hex,
                                              input logic enable, input int pos);
    longint unsigned rest;
    if (!enable) begin
        return seg_blank;
    end
    if (hex) begin
        return seg_pattern(value[4*pos +: 4]);
    end
    rest = value % 100000000;
    for (int i = 0; i < pos; i++) begin
        rest = rest / 10;
    end
    // nothing nonzero here or further left means a leading zero
    if (rest == 0 && pos != 0) begin
        return seg_blank;
    end
    return seg_pattern(4'(rest % 10));
endfunction

task automatic fail_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped on first error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        fail_run($sformatf("ERR %s got %h expected %h", name, actual, expected));
    end
endtask

`endif

//--- testbench/display_tb.sv
module display_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tube_pkg::*;

    localparam int ack_timeout   = 20;      // cycles per handshake edge
    localparam int settle_cycles = 45;      // worst case until a new value is on the tubes
    localparam int check_cycles  = 16;      // two full sweeps

    logic                   clk_tube;
    logic                   rst_n;
    logic                   host_req;
    logic                   host_addr;
    logic [value_width-1:0] host_wdata;
    logic                   host_ack;
    logic [6:0]             seg_tube;
    logic [digit_count-1:0] seg_enable;

    logic                   armed;
    logic [value_width-1:0] cur_value;
    logic                   cur_hex;
    logic                   cur_enable;

    `include "display_ref.svh"

    tube_display_top u_dut (
        .clk_tube   (clk_tube),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

    always #4 clk_tube = ~clk_tube;

    // lowest lit position, -1 when all tubes are off
    function automatic int active_position(input logic [digit_count-1:0] enables);
        int found;
        found = -1;
        for (int i = digit_count - 1; i >= 0; i--) begin
            if (!enables[i]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic host_write(input logic addr, input logic [value_width-1:0] data);
        int waited;
        @(negedge clk_tube);
        check_value("host_ack", host_ack, 0);   // ack must not lead req
        host_addr  = addr;
        host_wdata = data;
        host_req   = 1'b1;
        waited     = 0;
        while (host_ack !== 1'b1) begin
            @(negedge clk_tube);
            waited++;
            if (waited > ack_timeout) begin
                fail_run("timeout waiting for host_ack to rise after host_req");
            end
        end
        check_value("host_ack rise delay", waited, 1);
        @(negedge clk_tube);
        check_value("host_ack", host_ack, 1);   // held while req stays high
        host_req = 1'b0;
        waited   = 0;
        while (host_ack !== 1'b0) begin
            @(negedge clk_tube);
            waited++;
            if (waited > ack_timeout) begin
                fail_run("timeout waiting for host_ack to fall after host_req dropped");
            end
        end
        check_value("host_ack fall delay", waited, 1);
    endtask

    task automatic write_value(input logic [value_width-1:0] value);
        host_write(addr_value, value);
        cur_value = value;
    endtask

    task automatic write_ctrl(input logic enable, input logic hex);
        host_write(addr_ctrl, {30'd0, hex, enable});
        cur_enable = enable;
        cur_hex    = hex;
    endtask

    task automatic settle_and_check();
        for (int i = 0; i < settle_cycles; i++) begin
            @(negedge clk_tube);
        end
        armed <= 1'b1;
        for (int i = 0; i < check_cycles; i++) begin
            @(negedge clk_tube);
        end
        armed <= 1'b0;
    endtask

    task automatic show_value(input logic [value_width-1:0] value);
        write_value(value);
        settle_and_check();
    endtask

    // outputs are registered on the rising edge and read half a cycle later
    always @(negedge clk_tube) begin : compare_outputs
        int                     idx;
        logic [digit_count-1:0] onehot;
        if (rst_n) begin
            idx = active_position(seg_enable);
            if (idx >= 0) begin
                onehot      = '1;
                onehot[idx] = 1'b0;
                check_value("seg_enable", seg_enable, onehot);
            end
            if (armed) begin
                if (!cur_enable) begin
                    check_value("seg_enable", seg_enable, 8'hff);
                    check_value("seg_tube", seg_tube, seg_blank);
                end else if (idx < 0) begin
                    fail_run("no tube position is lit while the display is enabled");
                end else begin
                    check_value("seg_tube", seg_tube,
                                expected_glyph(cur_value, cur_hex, cur_enable, idx));
                end
            end
        end
    end

    initial begin
        clk_tube   = 1'b0;
        rst_n      = 1'b0;
        host_req   = 1'b0;
        host_addr  = 1'b0;
        host_wdata = '0;
        armed      = 1'b0;
        cur_value  = '0;
        cur_hex    = 1'b0;
        cur_enable = 1'b0;
        void'($urandom(34));
        repeat (8) @(negedge clk_tube);
        rst_n = 1'b1;

        settle_and_check();                 // dark after reset
        show_value(32'd12345);              // value loaded but still dark

        write_ctrl(1'b1, 1'b0);
        settle_and_check();
        show_value(32'd0);
        show_value(32'd100);
        show_value(32'd7);
        show_value(32'd10203040);           // inner zeros stay lit, position 4 too
        show_value(32'd99999999);

        show_value(32'd100000000);
        show_value(32'd123456789);
        show_value(32'hffff_ffff);
        for (int i = 0; i < 20; i++) begin
            show_value($urandom());
        end

        // second write lands inside the conversion window
        write_value(32'd11111111);
        show_value(32'd90807);

        write_ctrl(1'b1, 1'b1);
        show_value(32'h00ab_cdef);
        show_value(32'h0000_0f0e);
        for (int i = 0; i < 8; i++) begin
            show_value($urandom());
        end

        write_ctrl(1'b0, 1'b1);
        settle_and_check();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+testbench
design/tube_pkg.sv
design/tube_cfg_if.sv
design/tube_regs.sv
design/bin_to_bcd.sv
design/digit_scanner.sv
design/seg_decoder.sv
design/tube_display_top.sv
testbench/display_tb.sv
